/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_opb_qdr_sniffer
FILELIST  = all.f
EXE       = sim_$(TOP)
PASS_MSG  = All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(EXE)
	./obj_dir/$(EXE) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* all.f */
+incdir+source
source/qdr_sniffer_pkg.sv
source/opb_backdoor_bridge.sv
source/qdr_sniff_arbiter.sv
source/qdr_read_tracker.sv
source/opb_qdr_sniffer.sv
bench/qdr_memory_model.sv
bench/opb_qdr_sniffer_assertions.sv
bench/tb_opb_qdr_sniffer.sv

/* bench/opb_qdr_sniffer_assertions.sv */
`timescale 1ns/1ps

module opb_qdr_sniffer_assertions (
  input logic OPB_Clk,
  input logic reset,
  input qdr_sniffer_pkg::arb_state_e state,
  input logic fabric_ack,
  input logic backdoor_grant,
  input logic Sl_xferAck,
  input logic [0:31] Sl_DBus
);
  import qdr_sniffer_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // arbiter rules
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  state_onehot: assert property (@(posedge OPB_Clk) disable iff (reset) $onehot(state))
    else $error("arbiter state is not one-hot");

  // the backdoor slot is a single cycle, always followed by the wait state.
  backdoor_one_cycle: assert property (@(posedge OPB_Clk) disable iff (reset)
    (state == arb_backdoor) |=> (state == arb_backdoor_wait))
    else $error("backdoor state did not last exactly one cycle");

  ack_grant_exclusive: assert property (@(posedge OPB_Clk) disable iff (reset)
    !(fabric_ack && backdoor_grant))
    else $error("fabric_ack and backdoor_grant high together");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // OPB data bus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  dbus_idle_zero: assert property (@(posedge OPB_Clk) disable iff (reset)
    (Sl_DBus != '0) |-> Sl_xferAck)
    else $error("Sl_DBus driven outside an acknowledge");

endmodule

/* bench/qdr_memory_model.sv */
`timescale 1ns/1ps
`include "qdr_sniffer_settings.svh"

module qdr_memory_model (
  input  logic OPB_Clk,
  input  logic reset,
  input  qdr_sniffer_pkg::qdr_cmd_t master_cmd,
  output qdr_sniffer_pkg::qdr_word_u master_rd_data,
  output logic master_rd_dvld
);
  import qdr_sniffer_pkg::*;

  logic [35:0] mem [256];
  logic [35:0] pipe_data [`QDR_LATENCY];
  logic pipe_vld [`QDR_LATENCY];

  // read data is taken at the strobe and travels down a fixed latency line.
  always @(posedge OPB_Clk) begin
    if (reset) begin
      for (int i = 0; i < `QDR_LATENCY; i++) begin
        pipe_vld[i] <= 1'b0;
      end
      for (int j = 0; j < 256; j++) begin
        mem[j] <= '0;
      end
    end else begin
      pipe_vld[0]  <= master_cmd.rd;
      pipe_data[0] <= mem[master_cmd.addr[7:0]];
      for (int i = 1; i < `QDR_LATENCY; i++) begin
        pipe_vld[i]  <= pipe_vld[i-1];
        pipe_data[i] <= pipe_data[i-1];
      end
      // each enable covers one 9-bit byte, be[3] is the top of the hi beat.
      if (master_cmd.wr) begin
        if (master_cmd.be[3]) mem[master_cmd.addr[7:0]][35:27] <= master_cmd.data.halves.hi[17:9];
        if (master_cmd.be[2]) mem[master_cmd.addr[7:0]][26:18] <= master_cmd.data.halves.hi[8:0];
        if (master_cmd.be[1]) mem[master_cmd.addr[7:0]][17:9] <= master_cmd.data.halves.lo[17:9];
        if (master_cmd.be[0]) mem[master_cmd.addr[7:0]][8:0] <= master_cmd.data.halves.lo[8:0];
      end
    end
  end

  assign master_rd_dvld     = pipe_vld[`QDR_LATENCY-1];
  assign master_rd_data.raw = pipe_data[`QDR_LATENCY-1];

endmodule

/* bench/tb_opb_qdr_sniffer.sv */
`timescale 1ns/1ps
`include "qdr_sniffer_settings.svh"

module tb_opb_qdr_sniffer;
  import qdr_sniffer_pkg::*;

  localparam int MAX_ROWS = 20;
  localparam int ROW_CYCLES = 200;
  localparam int SIDE_ADDR = 200;

  typedef enum logic [2:0] {k_fab_wr, k_fab_rd, k_opb_wr, k_opb_rd, k_opb_out} kind_e;

  typedef struct packed {
    kind_e kind;
    logic [31:0] addr;
    logic [35:0] data;
    logic [3:0] be;
    logic contend;
    logic [35:0] side;
    logic [35:0] exp;
  } row_t;

  logic OPB_Clk;
  logic reset;
  logic [0:31] OPB_ABus;
  logic [0:3] OPB_BE;
  logic [0:31] OPB_DBus;
  logic OPB_RNW;
  logic OPB_select;
  logic OPB_seqAddr;
  logic [0:31] Sl_DBus;
  logic Sl_xferAck;
  logic Sl_toutSup;
  logic Sl_errAck;
  logic Sl_retry;
  qdr_cmd_t fabric_cmd;
  logic fabric_ack;
  qdr_word_u fabric_rd_data;
  logic fabric_rd_dvld;
  qdr_cmd_t master_cmd;
  qdr_word_u master_rd_data;
  logic master_rd_dvld;

  row_t rows [MAX_ROWS];
  int n_rows;
  logic [35:0] shadow [256];
  integer seed;
  int value_errors;
  int proto_errors;

  opb_qdr_sniffer i_opb_qdr_sniffer (.*);

  qdr_memory_model i_memory (
    .OPB_Clk        (OPB_Clk),
    .reset          (reset),
    .master_cmd     (master_cmd),
    .master_rd_data (master_rd_data),
    .master_rd_dvld (master_rd_dvld)
  );

  bind opb_qdr_sniffer opb_qdr_sniffer_assertions i_assertions (
    .OPB_Clk        (OPB_Clk),
    .reset          (reset),
    .state          (i_arbiter.state),
    .fabric_ack     (fabric_ack),
    .backdoor_grant (backdoor_grant),
    .Sl_xferAck     (Sl_xferAck),
    .Sl_DBus        (Sl_DBus)
  );

  initial OPB_Clk = 1'b0;
  always #5 OPB_Clk = ~OPB_Clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model of the packing rule
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [35:0] pack_opb(input logic [31:0] d);
    return {2'b00, d[31:16], 2'b00, d[15:0]};
  endfunction

  function automatic logic [31:0] unpack_qdr(input logic [35:0] w);
    return {w[33:18], w[15:0]};
  endfunction

  // one enable per 9-bit byte, highest enable at the top of the word.
  function automatic logic [35:0] merge_bytes(input logic [35:0] old_w, input logic [35:0] new_w,
                                              input logic [3:0] be);
    logic [35:0] w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) w[b*9 +: 9] = new_w[b*9 +: 9];
    end
    return w;
  endfunction

  function automatic logic [35:0] rand36();
    logic [31:0] a;
    logic [31:0] b;
    a = $random(seed);
    b = $random(seed);
    return {a[3:0], b};
  endfunction

  function automatic logic [7:0] qdr_index(input logic [31:0] byte_addr);
    logic [31:0] off;
    off = byte_addr - `QDR_BASEADDR;
    return off[9:2];
  endfunction

  // rows are built in order, so the shadow holds the memory as each row sees it.
  task automatic add_row(input kind_e kind, input logic [31:0] addr, input logic [35:0] data,
                         input logic [3:0] be, input logic contend);
    row_t r;
    r.kind = kind;
    r.addr = addr;
    r.data = data;
    r.be = be;
    r.contend = contend;
    r.side = contend ? rand36() : '0;
    r.exp = '0;
    if (contend) shadow[SIDE_ADDR] = r.side;
    case (kind)
      k_fab_wr: shadow[addr[7:0]] = merge_bytes(shadow[addr[7:0]], data, be);
      k_fab_rd: r.exp = shadow[addr[7:0]];
      k_opb_wr: shadow[qdr_index(addr)] = merge_bytes(shadow[qdr_index(addr)],
                                                       pack_opb(data[31:0]), be);
      k_opb_rd: r.exp = {4'h0, unpack_qdr(shadow[qdr_index(addr)])};
      default: r.exp = '0;
    endcase
    rows[n_rows] = r;
    n_rows++;
  endtask

  task automatic build_table();
    for (int i = 0; i < 256; i++) shadow[i] = '0;
    n_rows = 0;
    add_row(k_fab_wr, 32'd5, rand36(), 4'hF, 1'b0);
    add_row(k_fab_rd, 32'd5, '0, 4'hF, 1'b0);
    add_row(k_opb_wr, `QDR_BASEADDR + 32'h40, rand36(), 4'hF, 1'b0);
    add_row(k_opb_rd, `QDR_BASEADDR + 32'h40, '0, 4'hF, 1'b0);
    add_row(k_fab_rd, 32'd16, '0, 4'hF, 1'b0);
    add_row(k_fab_wr, 32'd20, rand36(), 4'hF, 1'b0);
    add_row(k_opb_rd, `QDR_BASEADDR + 32'h50, '0, 4'hF, 1'b0);
    add_row(k_opb_wr, `QDR_BASEADDR + 32'h40, rand36(), 4'b1100, 1'b0);
    add_row(k_opb_rd, `QDR_BASEADDR + 32'h40, '0, 4'hF, 1'b0);
    add_row(k_opb_wr, `QDR_BASEADDR + 32'h40, rand36(), 4'b0011, 1'b0);
    add_row(k_fab_rd, 32'd16, '0, 4'hF, 1'b0);
    add_row(k_opb_wr, `QDR_BASEADDR + 32'h60, rand36(), 4'hF, 1'b1);
    add_row(k_fab_rd, SIDE_ADDR, '0, 4'hF, 1'b0);
    add_row(k_opb_rd, `QDR_BASEADDR + 32'h60, '0, 4'hF, 1'b1);
    add_row(k_fab_rd, SIDE_ADDR, '0, 4'hF, 1'b0);
    add_row(k_opb_wr, `QDR_BASEADDR + 32'h3FC, rand36(), 4'hF, 1'b0);
    add_row(k_opb_rd, `QDR_BASEADDR + 32'h3FC, '0, 4'hF, 1'b0);
    add_row(k_opb_out, `QDR_HIGHADDR, '0, 4'hF, 1'b0);
    add_row(k_opb_out, `QDR_BASEADDR - 32'h4, '0, 4'hF, 1'b0);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus drivers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic fabric_issue(input qdr_cmd_t cmd);
    fabric_cmd = cmd;
    while (!fabric_ack) @(negedge OPB_Clk);
    @(negedge OPB_Clk);
    fabric_cmd = '0;
  endtask

  task automatic fabric_transfer(input row_t r);
    qdr_cmd_t cmd;
    int n;
    logic seen;
    cmd = '0;
    cmd.addr = r.addr[`QDR_ADDR_WIDTH-1:0];
    cmd.wr = (r.kind == k_fab_wr);
    cmd.rd = (r.kind == k_fab_rd);
    cmd.data.raw = r.data;
    cmd.be = r.be;
    fabric_issue(cmd);
    if (r.kind == k_fab_rd) begin
      n = 0;
      seen = 1'b0;
      while (!seen && n < 50) begin
        assert (!backdoor_qvld_seen() && !Sl_xferAck) else begin
          $display("backdoor acknowledge seen during a fabric read at row address %h", r.addr);
          proto_errors++;
        end
        if (fabric_rd_dvld) seen = 1'b1;
        else begin
          @(negedge OPB_Clk);
          n++;
        end
      end
      assert (seen) else begin
        $display("no fabric_rd_dvld within 50 cycles for address %h", r.addr);
        proto_errors++;
      end
      if (seen) begin
        assert (fabric_rd_data.raw == r.exp) else begin
          $display("[FAIL] fabric_rd_data got %h expected %h", fabric_rd_data.raw, r.exp);
          value_errors++;
        end
      end
      @(negedge OPB_Clk);
    end
  endtask

  function automatic logic backdoor_qvld_seen();
    return i_opb_qdr_sniffer.backdoor_qvld;
  endfunction

  task automatic opb_transfer(input row_t r);
    int n;
    int low;
    logic done;
    OPB_ABus = r.addr;
    OPB_BE = r.be;
    OPB_DBus = r.data[31:0];
    OPB_RNW = (r.kind == k_opb_rd);
    OPB_select = 1'b1;
    n = 0;
    low = 0;
    done = 1'b0;
    while (!done && n < 150) begin
      @(negedge OPB_Clk);
      n++;
      // the held fabric strobe meets the backdoor request in the same cycle.
      if (r.contend && n == 1) begin
        fabric_cmd.addr = `QDR_ADDR_WIDTH'(SIDE_ADDR);
        fabric_cmd.wr = 1'b1;
        fabric_cmd.data.raw = r.side;
        fabric_cmd.be = 4'hF;
      end else if (r.contend && n == 2) begin
        fabric_cmd = '0;
      end
      if (!fabric_ack) low++;
      assert (Sl_toutSup && !fabric_rd_dvld) else begin
        $display("Sl_toutSup low or fabric_rd_dvld high in cycle %0d of an OPB transfer", n);
        proto_errors++;
      end
      if (Sl_xferAck) done = 1'b1;
    end
    assert (done) else begin
      $display("no Sl_xferAck within 150 cycles for address %h", r.addr);
      proto_errors++;
    end
    if (done) begin
      assert (low == (r.contend ? 3 : 2)) else begin
        $display("[FAIL] fabric_ack low cycles got %h expected %h", low, r.contend ? 3 : 2);
        value_errors++;
      end
      assert (Sl_toutSup && !Sl_errAck && !Sl_retry) else begin
        $display("OPB status wrong at acknowledge, toutSup must be high and errAck, retry low");
        proto_errors++;
      end
      if (r.kind == k_opb_rd) begin
        assert (Sl_DBus == r.exp[31:0]) else begin
          $display("[FAIL] Sl_DBus got %h expected %h", Sl_DBus, r.exp[31:0]);
          value_errors++;
        end
      end
    end
    OPB_select = 1'b0;
    OPB_DBus = '0;
    @(negedge OPB_Clk);
    assert (Sl_DBus == '0) else begin
      $display("[FAIL] Sl_DBus got %h expected %h", Sl_DBus, 32'h0);
      value_errors++;
    end
  endtask

  task automatic opb_out_of_range(input row_t r);
    OPB_ABus = r.addr;
    OPB_RNW = 1'b1;
    OPB_select = 1'b1;
    repeat (50) begin
      @(negedge OPB_Clk);
      assert (!Sl_xferAck && Sl_DBus == '0) else begin
        $display("[FAIL] Sl_xferAck/Sl_DBus got %h/%h expected 0/0", Sl_xferAck, Sl_DBus);
        value_errors++;
      end
    end
    OPB_select = 1'b0;
    @(negedge OPB_Clk);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence and watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    #((ROW_CYCLES * MAX_ROWS + 40) * 10);
    $display("watchdog expired before all table rows were applied");
    $display("Checks failed");
    $finish;
  end

  initial begin
    seed = 35;
    value_errors = 0;
    proto_errors = 0;
    reset = 1'b1;
    OPB_ABus = '0;
    OPB_BE = '0;
    OPB_DBus = '0;
    OPB_RNW = 1'b0;
    OPB_select = 1'b0;
    OPB_seqAddr = 1'b0;
    fabric_cmd = '0;
    build_table();
    repeat (16) @(posedge OPB_Clk);
    @(negedge OPB_Clk);
    reset = 1'b0;
    @(negedge OPB_Clk);
    for (int i = 0; i < n_rows; i++) begin
      case (rows[i].kind)
        k_fab_wr, k_fab_rd: fabric_transfer(rows[i]);
        k_opb_wr, k_opb_rd: opb_transfer(rows[i]);
        default: opb_out_of_range(rows[i]);
      endcase
    end
    $display("value errors: %0d, protocol errors: %0d", value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* source/opb_backdoor_bridge.sv */
`timescale 1ns/1ps
`include "qdr_sniffer_settings.svh"

module opb_backdoor_bridge (
  input  logic OPB_Clk,
  input  logic reset,
  input  logic [0:31] OPB_ABus,
  input  logic [0:3] OPB_BE,
  input  logic [0:31] OPB_DBus,
  input  logic OPB_RNW,
  input  logic OPB_select,
  output logic [0:31] Sl_DBus,
  output logic Sl_xferAck,
  output logic Sl_toutSup,
  output logic Sl_errAck,
  output logic Sl_retry,
  output logic backdoor_req,
  input  logic backdoor_grant,
  output qdr_sniffer_pkg::qdr_cmd_t backdoor_cmd,
  input  qdr_sniffer_pkg::qdr_word_u backdoor_q,
  input  logic backdoor_qvld
);
  import qdr_sniffer_pkg::*;

  logic addr_match;
  logic start;
  logic busy;
  logic read_done;
  opb_req_t req;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // OPB side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign addr_match = (OPB_ABus >= `QDR_BASEADDR) && (OPB_ABus < `QDR_HIGHADDR);

  // a transfer starts on the first selected cycle inside the window.
  assign start = OPB_select && addr_match && !busy;

  // only backdoor reads come back through the tracker, so one pulse ends our read.
  assign read_done = busy && req.rnw && backdoor_qvld;

  // the transfer is held in this register until it has been acknowledged.
  always_ff @(posedge OPB_Clk) begin
    if (start) begin
      req.addr <= OPB_ABus - `QDR_BASEADDR;
      req.be   <= OPB_BE;
      req.data <= OPB_DBus;
      req.rnw  <= OPB_RNW;
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      busy         <= 1'b0;
      backdoor_req <= 1'b0;
      Sl_xferAck   <= 1'b0;
    end else begin
      Sl_xferAck <= 1'b0;
      if (start) begin
        busy         <= 1'b1;
        backdoor_req <= 1'b1;
      end
      // the arbiter issues our command in the grant cycle.
      if (backdoor_grant) begin
        backdoor_req <= 1'b0;
      end
      // writes finish with the grant, reads when their data returns.
      if ((busy && backdoor_grant && !req.rnw) || read_done) begin
        Sl_xferAck <= 1'b1;
      end
      if (Sl_xferAck) begin
        busy <= 1'b0;
      end
    end
  end

  // read data appears on the bus only in the acknowledge cycle.
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      Sl_DBus <= '0;
    end else if (read_done) begin
      Sl_DBus <= {backdoor_q.halves.hi[15:0], backdoor_q.halves.lo[15:0]};
    end else begin
      Sl_DBus <= '0;
    end
  end

  // the OPB master is told to wait for as long as we hold the transfer.
  assign Sl_toutSup = busy;
  assign Sl_errAck  = 1'b0;
  assign Sl_retry   = 1'b0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // QDR side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // lanes 0-1 fill the hi beat and lanes 2-3 the lo beat, top beat bits stay zero.
  always_comb begin
    backdoor_cmd.addr           = req.addr[`QDR_ADDR_WIDTH+1:2];
    backdoor_cmd.wr             = backdoor_req && !req.rnw;
    backdoor_cmd.rd             = backdoor_req && req.rnw;
    backdoor_cmd.data.halves.hi = {2'b00, req.data[0:15]};
    backdoor_cmd.data.halves.lo = {2'b00, req.data[16:31]};
    backdoor_cmd.be             = {req.be[0], req.be[1], req.be[2], req.be[3]};
  end

endmodule

/* source/opb_qdr_sniffer.sv */
`timescale 1ns/1ps

module opb_qdr_sniffer (
  input  logic OPB_Clk,
  input  logic reset,
  // OPB slave
  input  logic [0:31] OPB_ABus,
  input  logic [0:3] OPB_BE,
  input  logic [0:31] OPB_DBus,
  input  logic OPB_RNW,
  input  logic OPB_select,
  input  logic OPB_seqAddr,
  output logic [0:31] Sl_DBus,
  output logic Sl_xferAck,
  output logic Sl_toutSup,
  output logic Sl_errAck,
  output logic Sl_retry,
  // fabric port
  input  qdr_sniffer_pkg::qdr_cmd_t fabric_cmd,
  output logic fabric_ack,
  output qdr_sniffer_pkg::qdr_word_u fabric_rd_data,
  output logic fabric_rd_dvld,
  // controller port
  output qdr_sniffer_pkg::qdr_cmd_t master_cmd,
  input  qdr_sniffer_pkg::qdr_word_u master_rd_data,
  input  logic master_rd_dvld
);
  import qdr_sniffer_pkg::*;

  // single-word bridge transfers only, so OPB_seqAddr has no effect.

  logic backdoor_req;
  logic backdoor_grant;
  logic backdoor_qvld;
  qdr_cmd_t backdoor_cmd;
  qdr_word_u backdoor_q;

  opb_backdoor_bridge i_bridge (
    .OPB_Clk        (OPB_Clk),
    .reset          (reset),
    .OPB_ABus       (OPB_ABus),
    .OPB_BE         (OPB_BE),
    .OPB_DBus       (OPB_DBus),
    .OPB_RNW        (OPB_RNW),
    .OPB_select     (OPB_select),
    .Sl_DBus        (Sl_DBus),
    .Sl_xferAck     (Sl_xferAck),
    .Sl_toutSup     (Sl_toutSup),
    .Sl_errAck      (Sl_errAck),
    .Sl_retry       (Sl_retry),
    .backdoor_req   (backdoor_req),
    .backdoor_grant (backdoor_grant),
    .backdoor_cmd   (backdoor_cmd),
    .backdoor_q     (backdoor_q),
    .backdoor_qvld  (backdoor_qvld)
  );

  qdr_sniff_arbiter i_arbiter (
    .OPB_Clk        (OPB_Clk),
    .reset          (reset),
    .fabric_cmd     (fabric_cmd),
    .fabric_ack     (fabric_ack),
    .backdoor_cmd   (backdoor_cmd),
    .backdoor_req   (backdoor_req),
    .backdoor_grant (backdoor_grant),
    .master_cmd     (master_cmd)
  );

  qdr_read_tracker i_tracker (
    .OPB_Clk        (OPB_Clk),
    .reset          (reset),
    .master_cmd     (master_cmd),
    .backdoor_grant (backdoor_grant),
    .master_rd_data (master_rd_data),
    .master_rd_dvld (master_rd_dvld),
    .fabric_rd_data (fabric_rd_data),
    .fabric_rd_dvld (fabric_rd_dvld),
    .backdoor_q     (backdoor_q),
    .backdoor_qvld  (backdoor_qvld)
  );

endmodule

/* source/qdr_read_tracker.sv */
`timescale 1ns/1ps
`include "qdr_sniffer_settings.svh"

module qdr_read_tracker (
  input  logic OPB_Clk,
  input  logic reset,
  input  qdr_sniffer_pkg::qdr_cmd_t master_cmd,
  input  logic backdoor_grant,
  input  qdr_sniffer_pkg::qdr_word_u master_rd_data,
  input  logic master_rd_dvld,
  output qdr_sniffer_pkg::qdr_word_u fabric_rd_data,
  output logic fabric_rd_dvld,
  output qdr_sniffer_pkg::qdr_word_u backdoor_q,
  output logic backdoor_qvld
);

  // one tag per cycle of read latency.
  typedef struct packed {
    logic vld;
    logic backdoor;
  } rd_tag_t;

  rd_tag_t tag_line [`QDR_LATENCY];
  rd_tag_t tag_out;

  // a read issued under grant belongs to the backdoor, any other to the fabric.
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      for (int i = 0; i < `QDR_LATENCY; i++) begin
        tag_line[i] <= '0;
      end
    end else begin
      tag_line[0].vld      <= master_cmd.rd;
      tag_line[0].backdoor <= master_cmd.rd && backdoor_grant;
      for (int i = 1; i < `QDR_LATENCY; i++) begin
        tag_line[i] <= tag_line[i-1];
      end
    end
  end

  // the last stage lines up with the data-valid pulse of the same read.
  assign tag_out = tag_line[`QDR_LATENCY-1];

  assign fabric_rd_dvld = master_rd_dvld && tag_out.vld && !tag_out.backdoor;
  assign backdoor_qvld  = master_rd_dvld && tag_out.vld && tag_out.backdoor;

  // both owners see the data, only the valid pulse is steered.
  assign fabric_rd_data.raw = master_rd_data.raw;
  assign backdoor_q.raw     = master_rd_data.raw;

endmodule

/* source/qdr_sniff_arbiter.sv */
`timescale 1ns/1ps

module qdr_sniff_arbiter (
  input  logic OPB_Clk,
  input  logic reset,
  input  qdr_sniffer_pkg::qdr_cmd_t fabric_cmd,
  output logic fabric_ack,
  input  qdr_sniffer_pkg::qdr_cmd_t backdoor_cmd,
  input  logic backdoor_req,
  output logic backdoor_grant,
  output qdr_sniffer_pkg::qdr_cmd_t master_cmd
);
  import qdr_sniffer_pkg::*;

  arb_state_e state;
  logic fabric_pending;
  logic fabric_slot;

  assign fabric_pending = fabric_cmd.wr || fabric_cmd.rd;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the backdoor gets exactly one command slot per request.
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      state <= arb_slave;
    end else begin
      case (state)
        arb_slave: begin
          // a fabric strobe seen in this cycle is issued now, one more slave cycle follows.
          if (backdoor_req && fabric_pending) begin
            state <= arb_slave_wait;
          end else if (backdoor_req) begin
            state <= arb_backdoor;
          end
        end
        arb_slave_wait: begin
          state <= arb_backdoor;
        end
        arb_backdoor: begin
          state <= arb_backdoor_wait;
        end
        arb_backdoor_wait: begin
          state <= arb_slave;
        end
        default: begin
          state <= arb_slave;
        end
      endcase
    end
  end

  assign fabric_ack     = (state == arb_slave);
  assign backdoor_grant = (state == arb_backdoor);

  // write data and enables follow the fabric until the backdoor slot begins.
  assign fabric_slot = (state == arb_slave) || (state == arb_slave_wait);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // controller command mux
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    master_cmd.addr     = fabric_ack ? fabric_cmd.addr : backdoor_cmd.addr;
    master_cmd.wr       = (fabric_cmd.wr && fabric_ack) || (backdoor_cmd.wr && backdoor_grant);
    master_cmd.rd       = (fabric_cmd.rd && fabric_ack) || (backdoor_cmd.rd && backdoor_grant);
    master_cmd.data.raw = fabric_slot ? fabric_cmd.data.raw : backdoor_cmd.data.raw;
    master_cmd.be       = fabric_slot ? fabric_cmd.be : backdoor_cmd.be;
  end

endmodule

/* source/qdr_sniffer_pkg.sv */
`include "qdr_sniffer_settings.svh"

package qdr_sniffer_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // QDR data word
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one burst is two 18-bit beats, hi goes out first.
  typedef struct packed {
    logic [17:0] hi;
    logic [17:0] lo;
  } qdr_halves_t;

  // the same 36 bits seen as one raw word or as two beats.
  typedef union packed {
    logic [35:0] raw;
    qdr_halves_t halves;
  } qdr_word_u;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // commands and requests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a single controller command; be[3:2] enable the hi beat, be[1:0] the lo beat.
  typedef struct packed {
    logic [`QDR_ADDR_WIDTH-1:0] addr;
    logic wr;
    logic rd;
    qdr_word_u data;
    logic [3:0] be;
  } qdr_cmd_t;

  // an OPB transfer as captured by the bridge, in OPB bit order.
  typedef struct packed {
    logic [31:0] addr;
    logic [0:3] be;
    logic [0:31] data;
    logic rnw;
  } opb_req_t;

  // arbiter states, one-hot.
  typedef enum logic [3:0] {
    arb_slave         = 4'b0001,
    arb_slave_wait    = 4'b0010,
    arb_backdoor      = 4'b0100,
    arb_backdoor_wait = 4'b1000
  } arb_state_e;

endpackage

/* source/qdr_sniffer_settings.svh */
`ifndef QDR_SNIFFER_SETTINGS_SVH
`define QDR_SNIFFER_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// backdoor address window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// first OPB byte address that belongs to the backdoor.
`define QDR_BASEADDR 32'h0001_0000

// first OPB byte address past the backdoor window.
`define QDR_HIGHADDR 32'h0001_0400

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// controller geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// word address width on the controller port.
`define QDR_ADDR_WIDTH 20

// cycles from an accepted read strobe to the matching data-valid pulse.
`define QDR_LATENCY 10

`endif
